/* tb.f */
+incdir+verilog
verilog/mips_isa_pkg.sv
verilog/mips_ctrl_pkg.sv
verilog/mips_ctrl_if.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_decoder.sv
verilog/mips_datapath.sv
verilog/mips_cpu_harvard.sv
bench/tb_mips_mem.sv
bench/tb_mips_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mips_cpu
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_mips_cpu.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module tb_mips_cpu import mips_isa_pkg::*; ();

	logic clk, reset, clk_enable, active, data_write, data_read;
	logic [31:0] register_v0, instr_address, instr_readdata;
	logic [31:0] data_address, data_writedata, data_readdata;
	logic [31:0] lfsr, expect_v0, alu_v0;
	logic [31:0] prog [$];
	logic [31:0] alu_prog [$];
	logic [31:0] wr_addr_q [$]; // Writes the program should make
	logic [31:0] wr_data_q [$];
	int cycles, limit;

	mips_cpu_harvard dut (.*);

	tb_mips_mem mem (
		.clk(clk), .instr_address(instr_address), .instr_readdata(instr_readdata),
		.data_address(data_address), .data_write(data_write),
		.data_writedata(data_writedata), .data_readdata(data_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAIL at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Watchdog, budget set per test
	initial begin
		forever @(posedge clk) begin
			cycles++;
			if (limit > 0 && cycles > limit) begin
				$display("Run hung, the core never halted within %0d cycles", limit);
				$display("tests failed");
				$fatal(1);
			end
		end
	end

	// Every write strobe must match the next expected one, none while stalled
	always @(posedge clk) begin
		if (!reset && !clk_enable)
			check({30'h0, data_write, data_read}, 32'h0, "strobe while stalled");
		if (!reset && data_write) begin
			if (wr_addr_q.size() == 0) begin
				$display("Unexpected data write at %0t to %h", $time, data_address);
				$display("tests failed");
				$fatal(1);
			end
			check(data_address, wr_addr_q.pop_front(), "write address");
			check(data_writedata, wr_data_q.pop_front(), "write data");
		end
	end

	// Galois LFSR, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] get_bits(input int n);
		logic [31:0] r;
		r = 32'h0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// One bit at a time, sign bit copied in from the top
	function automatic logic [31:0] arith_shift_right(input logic [31:0] v, input logic [4:0] n);
		logic [31:0] r;
		r = v;
		for (int i = 0; i < n; i++)
			r = {r[31], r[31:1]};
		return r;
	endfunction

	function automatic logic [31:0] enc_r(funct_t f, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] sh);
		instr_u u;
		u.r.op = OP_SPECIAL;
		u.r.rs = rs;
		u.r.rt = rt;
		u.r.rd = rd;
		u.r.shamt = sh;
		u.r.funct = f;
		return u;
	endfunction

	function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		instr_u u;
		u.i.op = op;
		u.i.rs = rs;
		u.i.rt = rt;
		u.i.imm16 = imm;
		return u;
	endfunction

	function automatic logic [31:0] enc_j(opcode_t op, logic [31:0] target);
		instr_u u;
		u.i.op = op;
		{u.i.rs, u.i.rt, u.i.imm16} = target[27:2]; // Word index in the region
		return u;
	endfunction

	function automatic logic [31:0] next_addr();
		return `MIPS_RESET_VECTOR + 32'(prog.size()) * 32'd4;
	endfunction

	task automatic load_const(input logic [4:0] r, input logic [31:0] v);
		prog.push_back(enc_i(OP_LUI, 5'd0, r, v[31:16]));
		prog.push_back(enc_i(OP_ORI, r, r, v[15:0]));
	endtask

	// Result to r10, then v0 += r10
	task automatic emit_acc(input logic [31:0] w, input logic [31:0] val);
		prog.push_back(w);
		prog.push_back(enc_r(F_ADDU, 5'd2, 5'd10, 5'd2, 5'd0));
		expect_v0 = expect_v0 + val;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		clk_enable <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic load_and_reset();
		mem.clear_all();
		foreach (prog[i])
			mem.write_rom(i, prog[i]);
		apply_reset();
	endtask

	task automatic run_program(input bit stall, input string name);
		logic [31:0] pc_hold, v_hold;
		logic en_hold;
		load_and_reset();
		cycles = 0;
		limit = 4 * prog.size(); // Budget from program length
		@(negedge clk);
		pc_hold = instr_address;
		en_hold = clk_enable;
		while (active) begin
			@(posedge clk);
			if (stall)
				clk_enable <= (get_bits(2) != 32'h0); // Low one cycle in four
			@(negedge clk);
			if (!en_hold)
				check(instr_address, pc_hold, "PC moved while stalled");
			pc_hold = instr_address;
			en_hold = clk_enable;
		end
		limit = 0;
		v_hold = register_v0;
		repeat (3) @(negedge clk); // Halted core must stay put
		check(instr_address, `MIPS_HALT_ADDR, "PC moved after halt");
		check(register_v0, v_hold, "v0 changed after halt");
		check(register_v0, expect_v0, name);
		@(posedge clk);
		clk_enable <= 1'b1;
	endtask

	task automatic build_alu_prog();
		logic [31:0] a, b, imm_s;
		logic [15:0] imm;
		logic [4:0] sh;
		prog.delete();
		expect_v0 = 32'h0;
		a = get_bits(32);
		b = get_bits(32);
		sh = 5'(get_bits(5));
		imm = 16'(get_bits(16));
		imm_s = {{16{imm[15]}}, imm};
		load_const(5'd8, a);
		load_const(5'd9, b);
		emit_acc(enc_r(F_ADDU, 5'd8, 5'd9, 5'd10, 5'd0), a + b);
		emit_acc(enc_r(F_SUBU, 5'd8, 5'd9, 5'd10, 5'd0), a - b);
		emit_acc(enc_r(F_AND, 5'd8, 5'd9, 5'd10, 5'd0), a & b);
		emit_acc(enc_r(F_OR, 5'd8, 5'd9, 5'd10, 5'd0), a | b);
		emit_acc(enc_r(F_XOR, 5'd8, 5'd9, 5'd10, 5'd0), a ^ b);
		emit_acc(enc_r(F_SLT, 5'd8, 5'd9, 5'd10, 5'd0), {31'h0, $signed(a) < $signed(b)});
		emit_acc(enc_r(F_SLTU, 5'd8, 5'd9, 5'd10, 5'd0), {31'h0, a < b});
		emit_acc(enc_r(F_SLL, 5'd0, 5'd8, 5'd10, sh), a << sh);
		emit_acc(enc_r(F_SRL, 5'd0, 5'd8, 5'd10, sh), a >> sh);
		emit_acc(enc_r(F_SRA, 5'd0, 5'd8, 5'd10, sh), arith_shift_right(a, sh));
		emit_acc(enc_r(F_SLLV, 5'd9, 5'd8, 5'd10, 5'd0), a << b[4:0]);
		emit_acc(enc_r(F_SRLV, 5'd9, 5'd8, 5'd10, 5'd0), a >> b[4:0]);
		emit_acc(enc_r(F_SRAV, 5'd9, 5'd8, 5'd10, 5'd0), arith_shift_right(a, b[4:0]));
		emit_acc(enc_i(OP_ADDIU, 5'd8, 5'd10, imm), a + imm_s);
		emit_acc(enc_i(OP_ANDI, 5'd8, 5'd10, imm), a & {16'h0, imm});
		emit_acc(enc_i(OP_ORI, 5'd8, 5'd10, imm), a | {16'h0, imm});
		emit_acc(enc_i(OP_XORI, 5'd8, 5'd10, imm), a ^ {16'h0, imm});
		emit_acc(enc_i(OP_SLTI, 5'd8, 5'd10, imm), {31'h0, $signed(a) < $signed(imm_s)});
		emit_acc(enc_i(OP_SLTIU, 5'd8, 5'd10, imm), {31'h0, a < imm_s});
		emit_acc(enc_i(OP_LUI, 5'd0, 5'd10, imm), {imm, 16'h0});
		prog.push_back(enc_r(F_JR, 5'd0, 5'd0, 5'd0, 5'd0)); // Jump to halt address
		alu_prog = prog;
		alu_v0 = expect_v0;
	endtask

	task automatic test_reset();
		prog = alu_prog;
		load_and_reset();
		@(negedge clk);
		check(instr_address, `MIPS_RESET_VECTOR, "reset PC");
		check({31'h0, active}, 32'h1, "active after reset");
		check({30'h0, data_write, data_read}, 32'h0, "strobes after reset");
	endtask

	task automatic test_memory(input bit stall);
		logic [31:0] w [4];
		prog.delete();
		expect_v0 = 32'h0;
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h0100)); // Base address
		for (int k = 0; k < 4; k++) begin
			w[k] = get_bits(32);
			load_const(5'd9, w[k]);
			prog.push_back(enc_i(OP_SW, 5'd8, 5'd9, 16'(k * 4)));
			wr_addr_q.push_back(32'h100 + 32'(k * 4));
			wr_data_q.push_back(w[k]);
		end
		for (int k = 0; k < 4; k++)
			emit_acc(enc_i(OP_LW, 5'd8, 5'd10, 16'(k * 4)), w[k]);
		prog.push_back(enc_r(F_JR, 5'd0, 5'd0, 5'd0, 5'd0));
		run_program(stall, "load sum in v0");
		check(32'(wr_addr_q.size()), 32'h0, "writes missing");
		for (int k = 0; k < 4; k++)
			check(mem.read_ram(32'h100 + 32'(k * 4)), w[k], "stored word");
	endtask

	// Taken branch skips the add of its bit
	task automatic emit_branch(input logic [31:0] w, input bit taken, input int k);
		prog.push_back(w);
		prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'(1 << k)));
		if (!taken)
			expect_v0 = expect_v0 + 32'(1 << k);
	endtask

	task automatic test_control();
		logic [31:0] x, t;
		prog.delete();
		expect_v0 = 32'h0;
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'd5)); // r8 positive
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd9, 16'hFFFD)); // r9 = -3
		emit_branch(enc_i(OP_BEQ, 5'd8, 5'd8, 16'd1), 1'b1, 0);
		emit_branch(enc_i(OP_BEQ, 5'd8, 5'd9, 16'd1), 1'b0, 1);
		emit_branch(enc_i(OP_BNE, 5'd8, 5'd9, 16'd1), 1'b1, 2);
		emit_branch(enc_i(OP_BNE, 5'd8, 5'd8, 16'd1), 1'b0, 3);
		emit_branch(enc_i(OP_BLEZ, 5'd9, 5'd0, 16'd1), 1'b1, 4);
		emit_branch(enc_i(OP_BLEZ, 5'd8, 5'd0, 16'd1), 1'b0, 5);
		emit_branch(enc_i(OP_BGTZ, 5'd8, 5'd0, 16'd1), 1'b1, 6);
		emit_branch(enc_i(OP_BGTZ, 5'd9, 5'd0, 16'd1), 1'b0, 7);
		emit_branch(enc_i(OP_REGIMM, 5'd9, 5'd0, 16'd1), 1'b1, 8); // bltz
		emit_branch(enc_i(OP_REGIMM, 5'd8, 5'd0, 16'd1), 1'b0, 9);
		emit_branch(enc_i(OP_REGIMM, 5'd8, 5'd1, 16'd1), 1'b1, 10); // bgez
		emit_branch(enc_i(OP_REGIMM, 5'd9, 5'd1, 16'd1), 1'b0, 11);
		x = next_addr();
		prog.push_back(enc_j(OP_JAL, x + 32'd8));
		prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'h4000)); // Skipped
		prog.push_back(enc_r(F_ADDU, 5'd2, 5'd31, 5'd2, 5'd0)); // v0 += ra
		expect_v0 = expect_v0 + x + 32'd4;
		x = next_addr() + 32'd8; // jalr after the two constant loads
		t = x + 32'd8;
		load_const(5'd11, t);
		prog.push_back(enc_r(F_JALR, 5'd11, 5'd0, 5'd31, 5'd0));
		prog.push_back(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'h2000)); // Skipped
		prog.push_back(enc_r(F_ADDU, 5'd2, 5'd31, 5'd2, 5'd0));
		expect_v0 = expect_v0 + x + 32'd4;
		prog.push_back(enc_r(F_JR, 5'd0, 5'd0, 5'd0, 5'd0));
		run_program(1'b0, "branch pattern and links");
	endtask

	initial begin
		reset <= 1'b1;
		clk_enable <= 1'b1;
		cycles = 0;
		limit = 0;
		lfsr = 32'd70;
		build_alu_prog();
		test_reset();
		prog = alu_prog;
		expect_v0 = alu_v0;
		run_program(1'b0, "ALU accumulate");
		test_memory(1'b0);
		test_control();
		prog = alu_prog;
		expect_v0 = alu_v0;
		run_program(1'b1, "ALU accumulate with stalls");
		test_memory(1'b1); // Stores and loads under stalls
		$display("all tests passed");
		$finish;
	end

endmodule

/* bench/tb_mips_mem.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module tb_mips_mem (
	input logic clk,
	input logic [31:0] instr_address,
	output logic [31:0] instr_readdata,
	input logic [31:0] data_address,
	input logic data_write,
	input logic [31:0] data_writedata,
	output logic [31:0] data_readdata
);

	logic [31:0] rom [256]; // Program words from the reset vector up
	logic [31:0] ram [256]; // Data words, indexed by address bits 9:2
	logic [31:0] rom_off;

	assign rom_off = instr_address - `MIPS_RESET_VECTOR;
	// Outside the ROM window reads as addiu v0, v0, 1
	assign instr_readdata = (rom_off < 32'd1024) ? rom[rom_off[9:2]] : 32'h2442_0001;
	assign data_readdata = ram[data_address[9:2]]; // Zero-wait read

	always @(posedge clk) begin
		if (data_write)
			ram[data_address[9:2]] <= data_writedata;
	end

	task automatic clear_all();
		for (int i = 0; i < 256; i++) begin
			rom[i] = 32'h0;
			ram[i] <= 32'h0;
		end
	endtask

	task automatic write_rom(input int idx, input logic [31:0] w);
		rom[idx] = w;
	endtask

	function automatic logic [31:0] read_ram(input logic [31:0] addr);
		return ram[addr[9:2]];
	endfunction

endmodule

/* verilog/mips_cpu_harvard.sv */
`timescale 1ns/10ps

module mips_cpu_harvard (
	input logic clk,
	input logic reset,
	output logic active,
	output logic [31:0] register_v0,

	input logic clk_enable, // Low stalls the core

	output logic [31:0] instr_address, // Fetch address, the PC
	input logic [31:0] instr_readdata, // Same-cycle instruction

	output logic [31:0] data_address,
	output logic data_write,
	output logic data_read,
	output logic [31:0] data_writedata,
	input logic [31:0] data_readdata
);

	mips_ctrl_if ctl ();

	mips_decoder u_decoder (
		.ctl(ctl.decoder)
	);

	mips_datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.ctl(ctl.datapath),
		.active(active),
		.register_v0(register_v0),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_write(data_write),
		.data_read(data_read),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata)
	);

endmodule

/* verilog/mips_datapath.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module mips_datapath import mips_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	mips_ctrl_if.datapath ctl,
	output logic active,
	output logic [31:0] register_v0,
	output logic [31:0] instr_address,
	input logic [31:0] instr_readdata,
	output logic [31:0] data_address,
	output logic data_write,
	output logic data_read,
	output logic [31:0] data_writedata,
	input logic [31:0] data_readdata
);

	logic [31:0] pc, pc_plus4, pc_next;
	logic [31:0] branch_target, jump_target;
	logic [31:0] imm_ext, rs_val, rt_val, alu_b, alu_y, wb_data;
	logic [4:0] shamt, wr_addr;
	logic zero, neg, run, cmp_zero;

	assign ctl.instr = instr_readdata;
	assign instr_address = pc;
	assign active = (pc != `MIPS_HALT_ADDR); // Low once halted
	assign run = active && clk_enable; // Retire enable

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= `MIPS_RESET_VECTOR;
		else if (run)
			pc <= pc_next;
	end

	assign pc_plus4 = pc + 32'd4;

	// Immediate and operand selection
	assign imm_ext = ctl.ctrl.imm_zero_ext ? {16'h0000, ctl.instr.i.imm16}
		: {{16{ctl.instr.i.imm16[15]}}, ctl.instr.i.imm16};
	assign cmp_zero = ctl.cond inside {BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ};
	assign alu_b = ctl.ctrl.src_b_imm ? imm_ext : (cmp_zero ? '0 : rt_val);
	assign shamt = ctl.ctrl.shift_var ? rs_val[4:0] : ctl.instr.r.shamt;

	mips_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.we(ctl.ctrl.reg_write && run),
		.ra1(ctl.instr.r.rs),
		.ra2(ctl.instr.r.rt),
		.wa(wr_addr),
		.wd(wb_data),
		.rd1(rs_val),
		.rd2(rt_val),
		.v0(register_v0)
	);

	mips_alu u_alu (
		.op(ctl.ctrl.alu_op),
		.a(rs_val),
		.b(alu_b),
		.shamt(shamt),
		.y(alu_y),
		.zero(zero),
		.neg(neg)
	);

	always_comb begin
		case (ctl.cond)
			BR_EQ: ctl.taken = zero;
			BR_NE: ctl.taken = !zero;
			BR_LEZ: ctl.taken = neg || zero;
			BR_GTZ: ctl.taken = !neg && !zero;
			BR_LTZ: ctl.taken = neg;
			BR_GEZ: ctl.taken = !neg;
			default: ctl.taken = 1'b0;
		endcase
	end

	// Next PC, no delay slot
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], ctl.instr.i.rs, ctl.instr.i.rt,
		ctl.instr.i.imm16, 2'b00};

	always_comb begin
		case (ctl.ctrl.pc_sel)
			PC_BRANCH: pc_next = ctl.taken ? branch_target : pc_plus4;
			PC_JUMP: pc_next = jump_target;
			PC_REG: pc_next = rs_val; // jr/jalr
			default: pc_next = pc_plus4;
		endcase
	end

	// Write-back
	always_comb begin
		case (ctl.ctrl.dst_sel)
			DST_RD: wr_addr = ctl.instr.r.rd;
			DST_RA: wr_addr = `MIPS_REG_RA;
			default: wr_addr = ctl.instr.r.rt;
		endcase
	end

	assign wb_data = ctl.ctrl.link ? pc_plus4 : (ctl.ctrl.mem_read ? data_readdata : alu_y);

	// Data bus, strobes only while retiring
	assign data_address = alu_y;
	assign data_writedata = rt_val;
	assign data_write = ctl.ctrl.mem_write && run;
	assign data_read = ctl.ctrl.mem_read && run;

	a_pc_align: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("PC lost word alignment");

endmodule

/* verilog/mips_decoder.sv */
`timescale 1ns/10ps

module mips_decoder import mips_isa_pkg::*, mips_ctrl_pkg::*; (
	mips_ctrl_if.decoder ctl
);

	ctrl_t c;
	branch_t cond;

	always_comb begin
		c = CTRL_NOP;
		case (ctl.instr.r.op)
			OP_SPECIAL: begin
				c.reg_write = 1'b1; // Most SPECIAL ops write rd
				c.dst_sel = DST_RD;
				case (ctl.instr.r.funct)
					F_SLL: c.alu_op = ALU_SLL;
					F_SRL: c.alu_op = ALU_SRL;
					F_SRA: c.alu_op = ALU_SRA;
					F_SLLV: begin
						c.alu_op = ALU_SLL;
						c.shift_var = 1'b1;
					end
					F_SRLV: begin
						c.alu_op = ALU_SRL;
						c.shift_var = 1'b1;
					end
					F_SRAV: begin
						c.alu_op = ALU_SRA;
						c.shift_var = 1'b1;
					end
					F_JR: begin
						c.reg_write = 1'b0; // No link
						c.pc_sel = PC_REG;
					end
					F_JALR: begin
						c.pc_sel = PC_REG;
						c.link = 1'b1; // Link into rd
					end
					F_ADDU: c.alu_op = ALU_ADD;
					F_SUBU: c.alu_op = ALU_SUB;
					F_AND: c.alu_op = ALU_AND;
					F_OR: c.alu_op = ALU_OR;
					F_XOR: c.alu_op = ALU_XOR;
					F_SLT: c.alu_op = ALU_SLT;
					F_SLTU: c.alu_op = ALU_SLTU;
					default: c = CTRL_NOP; // Unknown funct
				endcase
			end
			OP_REGIMM: begin
				if (ctl.instr.i.rt inside {5'd0, 5'd1}) begin
					c.pc_sel = PC_BRANCH; // bltz/bgez only
				end
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: c.pc_sel = PC_BRANCH;
			OP_J: c.pc_sel = PC_JUMP;
			OP_JAL: begin
				c.pc_sel = PC_JUMP;
				c.reg_write = 1'b1;
				c.dst_sel = DST_RA;
				c.link = 1'b1;
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				c.reg_write = 1'b1; // Result to rt
				c.src_b_imm = 1'b1;
				c.imm_zero_ext = ctl.instr.i.op inside {OP_ANDI, OP_ORI, OP_XORI};
				case (ctl.instr.i.op)
					OP_SLTI: c.alu_op = ALU_SLT;
					OP_SLTIU: c.alu_op = ALU_SLTU; // Sign-extended, compared unsigned
					OP_ANDI: c.alu_op = ALU_AND;
					OP_ORI: c.alu_op = ALU_OR;
					OP_XORI: c.alu_op = ALU_XOR;
					OP_LUI: c.alu_op = ALU_LUI;
					default: c.alu_op = ALU_ADD; // addiu
				endcase
			end
			OP_LW: begin
				c.reg_write = 1'b1;
				c.src_b_imm = 1'b1; // Base plus offset
				c.mem_read = 1'b1;
			end
			OP_SW: begin
				c.src_b_imm = 1'b1;
				c.mem_write = 1'b1;
			end
			default: c = CTRL_NOP; // Undefined opcode runs as nop
		endcase
	end

	// Condition decode kept apart from the control word
	always_comb begin
		case (ctl.instr.i.op)
			OP_BEQ: cond = BR_EQ;
			OP_BNE: cond = BR_NE;
			OP_BLEZ: cond = BR_LEZ;
			OP_BGTZ: cond = BR_GTZ;
			OP_REGIMM: begin
				if (ctl.instr.i.rt == 5'd0)
					cond = BR_LTZ;
				else if (ctl.instr.i.rt == 5'd1)
					cond = BR_GEZ;
				else
					cond = BR_NONE;
			end
			default: cond = BR_NONE;
		endcase
	end

	assign ctl.ctrl = c;
	assign ctl.cond = cond;

	// Checked each time a new word arrives from fetch
	a_mem_excl: assert property (@(ctl.instr) !(ctl.ctrl.mem_read && ctl.ctrl.mem_write))
		else $error("decoder drives mem_read and mem_write together");

endmodule

/* verilog/mips_regfile.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module mips_regfile (
	input logic clk,
	input logic reset,
	input logic we,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	output logic [31:0] v0
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd; // r0 writes dropped
		end
	end

	// r0 stays zero by reset and by the write filter
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];
	assign v0 = regs[`MIPS_REG_V0]; // Always visible

	a_r0_zero: assert property (@(posedge clk) disable iff (reset)
		((ra1 == 5'd0) |-> (rd1 == '0)) and ((ra2 == 5'd0) |-> (rd2 == '0)))
		else $error("r0 read back nonzero");

endmodule

/* verilog/mips_alu.sv */
`timescale 1ns/10ps

module mips_alu import mips_ctrl_pkg::*; (
	input alu_op_t op,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [4:0] shamt,
	output logic [31:0] y,
	output logic zero,
	output logic neg
);

	// Flags compare a against b whatever the op
	assign zero = (a == b);
	assign neg = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLT: y = {31'b0, neg}; // Signed less-than
			ALU_SLTU: y = {31'b0, a < b};
			ALU_SLL: y = b << shamt; // Shifts act on rt
			ALU_SRL: y = b >> shamt;
			ALU_SRA: y = $unsigned($signed(b) >>> shamt);
			ALU_LUI: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

/* verilog/mips_ctrl_if.sv */
`timescale 1ns/10ps

interface mips_ctrl_if import mips_isa_pkg::*, mips_ctrl_pkg::*; ();

	instr_u instr; // Fetched word
	ctrl_t ctrl; // Decoded control
	branch_t cond; // Branch condition to test
	logic taken; // Condition met this cycle

	modport decoder (
		input instr,
		output ctrl, cond
	);

	modport datapath (
		output instr, taken,
		input ctrl, cond
	);

endinterface

/* verilog/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_t;

	// Destination register choice
	typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} dst_sel_t;

	// Next PC source
	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_t;

	// Branch condition on rs vs rt or rs vs zero
	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} branch_t;

	typedef struct packed {
		logic reg_write;
		dst_sel_t dst_sel;
		logic src_b_imm; // ALU b from immediate
		logic imm_zero_ext; // Logical immediates
		logic shift_var; // Shift amount from rs
		logic mem_read;
		logic mem_write;
		pc_sel_t pc_sel;
		logic link; // Write pc+4 back
		alu_op_t alu_op;
	} ctrl_t;

	// Everything inactive, sequential fetch
	localparam ctrl_t CTRL_NOP = '0;

endpackage

/* verilog/mips_isa_pkg.sv */
package mips_isa_pkg;

	// Major opcodes in bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, // R-format, funct decides
		OP_REGIMM = 6'h01, // bltz/bgez, rt decides
		OP_J = 6'h02,
		OP_JAL = 6'h03,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_BLEZ = 6'h06,
		OP_BGTZ = 6'h07,
		OP_ADDIU = 6'h09,
		OP_SLTI = 6'h0A,
		OP_SLTIU = 6'h0B,
		OP_ANDI = 6'h0C, // Zero-extended imm
		OP_ORI = 6'h0D, // Zero-extended imm
		OP_XORI = 6'h0E, // Zero-extended imm
		OP_LUI = 6'h0F,
		OP_LW = 6'h23,
		OP_SW = 6'h2B
	} opcode_t;

	// SPECIAL function codes in bits 5:0
	typedef enum logic [5:0] {
		F_SLL = 6'h00, // Also the canonical nop
		F_SRL = 6'h02,
		F_SRA = 6'h03,
		F_SLLV = 6'h04,
		F_SRLV = 6'h06,
		F_SRAV = 6'h07,
		F_JR = 6'h08,
		F_JALR = 6'h09,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND = 6'h24,
		F_OR = 6'h25,
		F_XOR = 6'h26,
		F_SLT = 6'h2A,
		F_SLTU = 6'h2B
	} funct_t;

	typedef struct packed {
		opcode_t op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t funct;
	} r_fmt_t;

	// Jump target is {rs, rt, imm16}
	typedef struct packed {
		opcode_t op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} i_fmt_t;

	// Same word seen as R-format or as I/J-format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

/* verilog/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Fetching here ends execution
`define MIPS_HALT_ADDR 32'h0000_0000

// Architectural register numbers
`define MIPS_REG_V0 5'd2 // Result register shown at the top level
`define MIPS_REG_RA 5'd31 // Link target of jal

`endif
